// ==== project.f ====
mac_rx_pkg.sv
mii_rx_deframer.sv
rx_async_fifo.sv
rx_dma_writer.sv
mac_rx_top.sv
tb_mac_rx_checker.sv
tb_mac_rx.sv

// ==== tb_mac_rx.sv ====
`timescale 1ns/1ps

module tb_mac_rx;
	import mac_rx_pkg::*;

	localparam int     MTU        = 64;
	localparam int     SYS_PERIOD = 100;
	localparam int     PHY_PERIOD = 400;
	localparam int     IFG_NIBS   = 24;   // 12 byte times.
	localparam int     MAX_LEN    = 70;
	localparam int     N_FRAMES   = 12;
	localparam longint FRAME_NS   = (16 + 2 * MAX_LEN + IFG_NIBS) * PHY_PERIOD;
	localparam longint LIMIT_NS   = N_FRAMES * FRAME_NS + 50000;  // Reset and drain margin.
	localparam int     SEED       = 32'h29bd;

	logic                  sys_clk = 1'b0;
	logic                  sys_rst;
	logic                  phy_rx_clk = 1'b0;
	logic                  phy_dv;
	logic                  phy_rx_er;
	logic [3:0]            phy_rx_data;
	logic                  rx_valid;
	logic [WORD_ADR_W-1:0] rx_adr;
	logic                  bus_stb;
	bus_wr_t               bus_wr;
	logic                  bus_ack = 1'b0;
	logic                  frame_done;
	logic                  frame_drop;
	logic [LEN_W-1:0]      frame_len;

	integer seed     = SEED;
	integer ack_seed = SEED ^ 32'h5a5a;  // Separate stream for the bus slave.

	logic [31:0] mem [logic [WORD_ADR_W-1:0]];
	int          ack_wait = 0;

	always #(SYS_PERIOD / 2) sys_clk = ~sys_clk;
	always #(PHY_PERIOD / 2) phy_rx_clk = ~phy_rx_clk;

	mac_rx_top #(
		.MTU             (MTU),
		.FIFO_DEPTH_LOG2 (4)
	) i_mac_rx_top (
		.sys_clk       (sys_clk),
		.sys_rst       (sys_rst),
		.phy_rx_clk_i  (phy_rx_clk),
		.phy_dv_i      (phy_dv),
		.phy_rx_er_i   (phy_rx_er),
		.phy_rx_data_i (phy_rx_data),
		.rx_valid_i    (rx_valid),
		.rx_adr_i      (rx_adr),
		.bus_stb_o     (bus_stb),
		.bus_wr_o      (bus_wr),
		.bus_ack_i     (bus_ack),
		.frame_done_o  (frame_done),
		.frame_drop_o  (frame_drop),
		.frame_len_o   (frame_len)
	);

	tb_mac_rx_checker #(
		.MTU (MTU)
	) i_checker (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.bus_stb_i    (bus_stb),
		.bus_wr_i     (bus_wr),
		.bus_ack_i    (bus_ack),
		.frame_done_i (frame_done),
		.frame_drop_i (frame_drop),
		.frame_len_i  (frame_len)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus slave memory
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(negedge sys_clk) begin
		if (sys_rst) begin
			bus_ack  <= 1'b0;
			ack_wait <= 0;
		end else if (bus_ack) begin
			bus_ack  <= 1'b0;                             // Taken at the last rising edge.
			ack_wait <= $unsigned($random(ack_seed)) % 4;
		end else if (bus_stb) begin
			if (ack_wait == 0) begin
				bus_ack          <= 1'b1;
				mem[bus_wr.adr] = bus_wr.dat;
			end else begin
				ack_wait <= ack_wait - 1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// MII stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic drive_nibble(input logic dv, input logic [3:0] nib, input logic er);
		@(negedge phy_rx_clk);
		phy_dv      = dv;
		phy_rx_data = nib;
		phy_rx_er   = er;
	endtask

	// Random payload, er_nib selects the data nibble with rx_er, -1 for none.
	task automatic send_frame(input string name, input string kind, input int len,
			input logic [WORD_ADR_W-1:0] adr, input int er_nib);
		logic [7:0] fb [$];
		int         i;
		i_checker.add_frame(name, kind, adr, len);
		for (i = 0; i < len; i++) begin
			fb.push_back(8'($random(seed)));
			i_checker.add_byte(fb[i]);
		end
		@(negedge sys_clk);
		rx_adr = adr;
		for (i = 0; i < 15; i++)
			drive_nibble(1'b1, 4'h5, 1'b0);
		drive_nibble(1'b1, 4'hd, 1'b0);            // Delimiter high nibble.
		for (i = 0; i < len; i++) begin
			drive_nibble(1'b1, fb[i][3:0], er_nib == 2 * i);
			drive_nibble(1'b1, fb[i][7:4], er_nib == 2 * i + 1);
		end
		for (i = 0; i < IFG_NIBS; i++)
			drive_nibble(1'b0, 4'h0, 1'b0);
	endtask

	initial begin
		int k;
		int len;
		sys_rst     = 1'b1;
		phy_dv      = 1'b0;
		phy_rx_er   = 1'b0;
		phy_rx_data = 4'h0;
		rx_valid    = 1'b1;
		rx_adr      = '0;
		repeat (3) @(negedge sys_clk);
		sys_rst = 1'b0;
		repeat (80) @(negedge sys_clk);            // PHY side leaves reset later.

		send_frame("good_60", "done", 60, 30'h100, -1);
		send_frame("len_61", "done", 61, 30'h200, -1);
		send_frame("len_62", "done", 62, 30'h300, -1);
		send_frame("len_63", "done", 63, 30'h400, -1);
		send_frame("rx_er", "rx_er", 41, 30'h500, 21);
		send_frame("over_mtu", "mtu", MAX_LEN, 30'h600, -1);
		send_frame("after_mtu", "done", 60, 30'h700, -1);
		@(negedge sys_clk);
		rx_valid = 1'b0;                           // No slot for the next frame.
		send_frame("no_slot", "no_slot", 40, 30'h800, -1);
		@(negedge sys_clk);
		rx_valid = 1'b1;
		for (k = 0; k < 4; k++) begin
			len = 20 + int'($unsigned($random(seed)) % 45);
			send_frame($sformatf("b2b_%0d", k), "done", len, 30'h1000 + 30'(k * 'h40), -1);
		end

		while (i_checker.pending() != 0)
			@(negedge sys_clk);
		repeat (40) @(negedge sys_clk);            // Catch late extra writes.
		i_checker.check_word_count(mem.num());
		i_checker.finish_report();
		if (i_checker.total_errors() == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// Watchdog.
	initial begin
		#(LIMIT_NS);
		$display("Timeout: frames still outstanding after %0d ns", LIMIT_NS);
		i_checker.finish_report();
		$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== tb_mac_rx_checker.sv ====
`timescale 1ns/1ps

module tb_mac_rx_checker #(
	parameter int MTU = 64
) (
	input logic                         sys_clk,
	input logic                         sys_rst,
	input logic                         bus_stb_i,
	input mac_rx_pkg::bus_wr_t          bus_wr_i,
	input logic                         bus_ack_i,
	input logic                         frame_done_i,
	input logic                         frame_drop_i,
	input logic [mac_rx_pkg::LEN_W-1:0] frame_len_i
);
	import mac_rx_pkg::*;

	typedef logic [7:0] byte_q_t [$];

	string                 exp_name [$];
	string                 exp_kind [$];  // done, rx_er, mtu or no_slot.
	logic [WORD_ADR_W-1:0] exp_adr [$];
	int                    exp_len [$];
	byte_q_t               exp_bytes;     // Bytes of all queued frames, oldest first.
	int                    wr_idx = 0;    // Writes seen so far for the head frame.
	int                    exp_words = 0; // Words all frames leave in memory.
	int                    data_errors = 0;
	int                    len_errors = 0;
	int                    strobe_errors = 0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Expected frames from the stimulus side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic add_frame(input string name, input string kind,
			input logic [WORD_ADR_W-1:0] adr, input int len);
		exp_name.push_back(name);
		exp_kind.push_back(kind);
		exp_adr.push_back(adr);
		exp_len.push_back(len);
		exp_words += expected_writes(kind, len);
	endtask

	task automatic add_byte(input logic [7:0] b);
		exp_bytes.push_back(b);
	endtask

	function automatic int pending();
		return exp_name.size();
	endfunction

	function automatic int total_errors();
		return data_errors + len_errors + strobe_errors;
	endfunction

	// Words that reach memory. A bad frame stops before its partial word.
	function automatic int expected_writes(input string kind, input int n);
		if (kind == "done")
			return (n + 3) / 4;
		if (kind == "rx_er")
			return n / 4;
		if (kind == "mtu")
			return MTU / 4;  // Only full words below the limit.
		return 0;
	endfunction

	// Word idx of a frame, big-endian, unused low lanes zero.
	function automatic bus_wr_t ref_write(input byte_q_t fb, input int n,
			input logic [WORD_ADR_W-1:0] start_adr, input int idx);
		bus_wr_t w;
		int      lane;
		w.adr = start_adr + WORD_ADR_W'(idx);
		w.dat = '0;
		for (lane = 0; lane < 4; lane++) begin
			if (idx * 4 + lane < n)
				w.dat[31 - 8 * lane -: 8] = fb[idx * 4 + lane];
		end
		return w;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Comparison
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_write();
		bus_wr_t exp;
		if (exp_name.size() == 0) begin
			$display("Bus write to word %h while no frame was expected", bus_wr_i.adr);
			strobe_errors++;
		end else begin
			if (wr_idx < expected_writes(exp_kind[0], exp_len[0])) begin
				exp = ref_write(exp_bytes, exp_len[0], exp_adr[0], wr_idx);
				if (bus_wr_i !== exp) begin
					$display("Error: %s write %0d: expected adr %h dat %h, actual adr %h dat %h",
						exp_name[0], wr_idx, exp.adr, exp.dat, bus_wr_i.adr, bus_wr_i.dat);
					data_errors++;
				end
			end
			wr_idx++;  // Extra writes show up in the count check.
		end
	endtask

	task automatic check_end();
		int n_exp;
		if (exp_name.size() == 0) begin
			$display("Frame status strobe while no frame was expected");
			strobe_errors++;
		end else begin
			n_exp = expected_writes(exp_kind[0], exp_len[0]);
			if (frame_done_i && exp_kind[0] != "done") begin
				$display("Frame %s completed but should have been dropped", exp_name[0]);
				strobe_errors++;
			end else if (frame_done_i && frame_len_i !== LEN_W'(exp_len[0])) begin
				$display("Error: %s frame_len: expected %0d, actual %0d",
					exp_name[0], exp_len[0], frame_len_i);
				len_errors++;
			end else if (frame_drop_i && exp_kind[0] == "done") begin
				$display("Frame %s was dropped but should have completed", exp_name[0]);
				strobe_errors++;
			end
			if (wr_idx != n_exp) begin
				$display("Error: %s write count: expected %0d, actual %0d",
					exp_name[0], n_exp, wr_idx);
				data_errors++;
			end
			repeat (exp_len[0]) void'(exp_bytes.pop_front());
			void'(exp_name.pop_front());
			void'(exp_kind.pop_front());
			void'(exp_adr.pop_front());
			void'(exp_len.pop_front());
			wr_idx = 0;
		end
	endtask

	always @(posedge sys_clk) begin
		if (!sys_rst) begin
			if (bus_stb_i && bus_ack_i)
				check_write();
			if (frame_done_i || frame_drop_i)
				check_end();  // Same edge as the last write in SENDLAST.
		end
	end

	// Words of dropped frames stay in memory, so every frame counts.
	task automatic check_word_count(input int n);
		if (n != exp_words) begin
			$display("Error: memory word count: expected %0d, actual %0d", exp_words, n);
			data_errors++;
		end
	endtask

	task automatic finish_report();
		foreach (exp_name[i])
			$display("Frame %s never reported completion or drop", exp_name[i]);
		strobe_errors += exp_name.size();
		$display("Errors: data %0d, length %0d, strobe %0d, total %0d",
			data_errors, len_errors, strobe_errors, total_errors());
	endtask

endmodule

// ==== mac_rx_top.sv ====
`timescale 1ns/1ps

module mac_rx_top #(
	parameter int unsigned MTU             = 1500,
	parameter int unsigned FIFO_DEPTH_LOG2 = 4
) (
	input  logic                              sys_clk,
	input  logic                              sys_rst,
	input  logic                              phy_rx_clk_i,
	input  logic                              phy_dv_i,
	input  logic                              phy_rx_er_i,
	input  logic [3:0]                        phy_rx_data_i,
	input  logic                              rx_valid_i,
	input  logic [mac_rx_pkg::WORD_ADR_W-1:0] rx_adr_i,
	output logic                              bus_stb_o,
	output mac_rx_pkg::bus_wr_t               bus_wr_o,
	input  logic                              bus_ack_i,
	output logic                              frame_done_o,
	output logic                              frame_drop_o,
	output logic [mac_rx_pkg::LEN_W-1:0]      frame_len_o
);
	import mac_rx_pkg::*;

	logic [4:0] rst_cnt;      // Stretches sys_rst so the slow PHY clock sees it.
	logic       rst_req;
	logic       phy_rst_meta;
	logic       phy_rst;

	logic     fifo_wr;
	logic     fifo_full;
	logic     fifo_empty;
	logic     fifo_ack;
	rx_byte_t fifo_wdata;
	rx_byte_t fifo_rdata;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reset into the PHY domain
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			rst_cnt <= '1;
		else if (rst_cnt != '0)
			rst_cnt <= rst_cnt - 1'b1;
		rst_req <= sys_rst | (|rst_cnt);
	end

	always_ff @(posedge phy_rx_clk_i) begin
		phy_rst_meta <= rst_req;
		phy_rst      <= phy_rst_meta;
	end

	mii_rx_deframer i_deframer (
		.phy_rx_clk_i  (phy_rx_clk_i),
		.phy_rst_i     (phy_rst),
		.phy_dv_i      (phy_dv_i),
		.phy_rx_er_i   (phy_rx_er_i),
		.phy_rx_data_i (phy_rx_data_i),
		.fifo_full_i   (fifo_full),
		.fifo_wr_o     (fifo_wr),
		.fifo_wdata_o  (fifo_wdata)
	);

	// Read side held in reset until the write pointers are cleared too.
	rx_async_fifo #(
		.payload_t  (rx_byte_t),
		.DEPTH_LOG2 (FIFO_DEPTH_LOG2)
	) i_fifo (
		.wr_clk_i   (phy_rx_clk_i),
		.wr_rst_i   (phy_rst),
		.wr_en_i    (fifo_wr),
		.wr_data_i  (fifo_wdata),
		.wr_full_o  (fifo_full),
		.rd_clk_i   (sys_clk),
		.rd_rst_i   (rst_req),
		.rd_ack_i   (fifo_ack),
		.rd_data_o  (fifo_rdata),
		.rd_empty_o (fifo_empty)
	);

	rx_dma_writer #(
		.MTU (MTU)
	) i_writer (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.fifo_empty_i (fifo_empty),
		.fifo_data_i  (fifo_rdata),
		.fifo_ack_o   (fifo_ack),
		.rx_valid_i   (rx_valid_i),
		.rx_adr_i     (rx_adr_i),
		.bus_stb_o    (bus_stb_o),
		.bus_wr_o     (bus_wr_o),
		.bus_ack_i    (bus_ack_i),
		.frame_done_o (frame_done_o),
		.frame_drop_o (frame_drop_o),
		.frame_len_o  (frame_len_o)
	);

endmodule

// ==== rx_dma_writer.sv ====
`timescale 1ns/1ps

module rx_dma_writer #(
	parameter int unsigned MTU = 1500
) (
	input  logic                              sys_clk,
	input  logic                              sys_rst,
	input  logic                              fifo_empty_i,
	input  mac_rx_pkg::rx_byte_t              fifo_data_i,
	output logic                              fifo_ack_o,
	input  logic                              rx_valid_i,
	input  logic [mac_rx_pkg::WORD_ADR_W-1:0] rx_adr_i,
	output logic                              bus_stb_o,
	output mac_rx_pkg::bus_wr_t               bus_wr_o,
	input  logic                              bus_ack_i,
	output logic                              frame_done_o,
	output logic                              frame_drop_o,
	output logic [mac_rx_pkg::LEN_W-1:0]      frame_len_o
);
	import mac_rx_pkg::*;

	localparam logic [LEN_W-1:0] MTU_LEN = LEN_W'(MTU);

	typedef enum logic [2:0] {
		IDLE,
		LOADBYTE,
		WBSTROBE,
		SENDLAST,
		NOMORE
	} state_t;

	state_t state;
	state_t next_state;

	logic                  in_frame;
	logic [1:0]            byte_cnt;   // Lane of the next byte.
	logic [LEN_W-1:0]      len;
	logic [WORD_ADR_W-1:0] adr;
	logic [31:0]           word;

	logic start_frame;
	logic end_frame;
	logic load_en;
	logic adr_inc;

	assign bus_wr_o    = '{adr: adr, dat: word};
	assign frame_len_o = len;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Frame FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		next_state   = state;
		fifo_ack_o   = 1'b0;
		bus_stb_o    = 1'b0;
		frame_done_o = 1'b0;
		frame_drop_o = 1'b0;
		start_frame  = 1'b0;
		end_frame    = 1'b0;
		load_en      = 1'b0;
		adr_inc      = 1'b0;

		case (state)
			IDLE: begin
				if (!fifo_empty_i) begin
					if (fifo_data_i.eof) begin
						if (!in_frame) begin
							fifo_ack_o = 1'b1;          // Empty frame, nothing to report.
						end else if (fifo_data_i.bad) begin
							next_state = NOMORE;        // Status entry is popped there.
						end else begin
							fifo_ack_o = 1'b1;
							end_frame  = 1'b1;
							if (byte_cnt == 2'd0)
								frame_done_o = 1'b1;    // Ended on a word boundary.
							else
								next_state = SENDLAST;
						end
					end else if (!in_frame) begin
						if (rx_valid_i) begin
							start_frame = 1'b1;
							next_state  = LOADBYTE;
						end else begin
							next_state = NOMORE;        // No slot for this frame.
						end
					end else if (len == MTU_LEN) begin
						next_state = NOMORE;            // One byte past MTU.
					end else begin
						next_state = LOADBYTE;
					end
				end
			end
			LOADBYTE: begin
				fifo_ack_o = 1'b1;
				load_en    = 1'b1;
				if (byte_cnt == 2'd3)
					next_state = WBSTROBE;
				else
					next_state = IDLE;
			end
			WBSTROBE: begin
				bus_stb_o = 1'b1;
				if (bus_ack_i) begin
					adr_inc    = 1'b1;
					next_state = IDLE;
				end
			end
			SENDLAST: begin
				bus_stb_o = 1'b1;
				if (bus_ack_i) begin
					frame_done_o = 1'b1;
					next_state   = IDLE;
				end
			end
			NOMORE: begin
				if (!fifo_empty_i) begin
					fifo_ack_o = 1'b1;                  // Flush up to the status entry.
					if (fifo_data_i.eof) begin
						frame_drop_o = 1'b1;
						end_frame    = 1'b1;
						next_state   = IDLE;
					end
				end
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state    <= IDLE;
			in_frame <= 1'b0;
			byte_cnt <= 2'd0;
			len      <= '0;
		end else begin
			state <= next_state;
			if (start_frame) begin
				in_frame <= 1'b1;
				byte_cnt <= 2'd0;
				len      <= '0;
			end
			if (end_frame)
				in_frame <= 1'b0;
			if (load_en) begin
				byte_cnt <= byte_cnt + 2'd1;
				len      <= len + 1'b1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address and word packing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge sys_clk) begin
		if (start_frame)
			adr <= rx_adr_i;                         // Slot start.
		else if (adr_inc)
			adr <= adr + 1'b1;
		if (load_en) begin
			case (byte_cnt)
				2'd0: word        <= {fifo_data_i.data, 24'h000000};  // New word, low lanes cleared.
				2'd1: word[23:16] <= fifo_data_i.data;
				2'd2: word[15:8]  <= fifo_data_i.data;
				2'd3: word[7:0]   <= fifo_data_i.data;
			endcase
		end
	end

endmodule

// ==== rx_async_fifo.sv ====
`timescale 1ns/1ps

module rx_async_fifo #(
	parameter type payload_t  = logic [7:0],
	parameter int  DEPTH_LOG2 = 4
) (
	input  logic     wr_clk_i,
	input  logic     wr_rst_i,
	input  logic     wr_en_i,
	input  payload_t wr_data_i,
	output logic     wr_full_o,
	input  logic     rd_clk_i,
	input  logic     rd_rst_i,
	input  logic     rd_ack_i,
	output payload_t rd_data_o,
	output logic     rd_empty_o
);

	localparam int DEPTH = 1 << DEPTH_LOG2;
	localparam int PW    = DEPTH_LOG2 + 1;  // Pointer width, one wrap bit.

	payload_t mem [DEPTH];

	logic [PW-1:0] wr_bin;
	logic [PW-1:0] wr_bin_next;
	logic [PW-1:0] wr_gray;
	logic [PW-1:0] wr_gray_next;
	logic [PW-1:0] rd_gray_s1;
	logic [PW-1:0] rd_gray_s2;

	logic [PW-1:0] rd_bin;
	logic [PW-1:0] rd_bin_next;
	logic [PW-1:0] rd_gray;
	logic [PW-1:0] rd_gray_next;
	logic [PW-1:0] wr_gray_s1;
	logic [PW-1:0] wr_gray_s2;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign wr_bin_next  = wr_bin + PW'(wr_en_i & ~wr_full_o);
	assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

	// Full when the read pointer is one wrap behind, top two gray bits inverted.
	assign wr_full_o = (wr_gray == {~rd_gray_s2[PW-1:PW-2], rd_gray_s2[PW-3:0]});

	always_ff @(posedge wr_clk_i) begin
		if (wr_rst_i) begin
			wr_bin     <= '0;
			wr_gray    <= '0;
			rd_gray_s1 <= '0;
			rd_gray_s2 <= '0;
		end else begin
			wr_bin     <= wr_bin_next;
			wr_gray    <= wr_gray_next;
			rd_gray_s1 <= rd_gray;     // Two-flop crossing of the read pointer.
			rd_gray_s2 <= rd_gray_s1;
		end
	end

	always_ff @(posedge wr_clk_i) begin
		if (wr_en_i && !wr_full_o)
			mem[wr_bin[DEPTH_LOG2-1:0]] <= wr_data_i;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign rd_bin_next  = rd_bin + PW'(rd_ack_i & ~rd_empty_o);
	assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

	assign rd_empty_o = (rd_gray == wr_gray_s2);
	assign rd_data_o  = mem[rd_bin[DEPTH_LOG2-1:0]];  // Head entry falls through.

	always_ff @(posedge rd_clk_i) begin
		if (rd_rst_i) begin
			rd_bin     <= '0;
			rd_gray    <= '0;
			wr_gray_s1 <= '0;
			wr_gray_s2 <= '0;
		end else begin
			rd_bin     <= rd_bin_next;
			rd_gray    <= rd_gray_next;
			wr_gray_s1 <= wr_gray;     // Two-flop crossing of the write pointer.
			wr_gray_s2 <= wr_gray_s1;
		end
	end

endmodule

// ==== mii_rx_deframer.sv ====
`timescale 1ns/1ps

module mii_rx_deframer (
	input  logic                 phy_rx_clk_i,
	input  logic                 phy_rst_i,
	input  logic                 phy_dv_i,
	input  logic                 phy_rx_er_i,
	input  logic [3:0]           phy_rx_data_i,
	input  logic                 fifo_full_i,
	output logic                 fifo_wr_o,
	output mac_rx_pkg::rx_byte_t fifo_wdata_o
);
	import mac_rx_pkg::*;

	logic       dv_q;       // Previous phy_dv, for edge detection.
	logic       nib_5;      // Last nibble could open the delimiter.
	logic       sfd_seen;   // Delimiter found, now in the data part.
	logic       hi_nib;     // Next nibble completes a byte.
	logic [3:0] low_nib;
	logic       err;        // Sticky rx_er for this frame.
	logic       ovf;        // Sticky overflow for this frame.
	logic       lost;
	logic       eof_hold;
	logic       byte_done;
	logic       frame_end;

	assign lost      = fifo_wr_o & fifo_full_i;  // This cycle's write is refused.
	assign eof_hold  = lost & fifo_wdata_o.eof;  // Status entry must wait for space.
	assign byte_done = phy_dv_i & sfd_seen & hi_nib;
	assign frame_end = ~phy_dv_i & dv_q & sfd_seen;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Framing control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge phy_rx_clk_i) begin
		if (phy_rst_i) begin
			dv_q      <= 1'b0;
			nib_5     <= 1'b0;
			sfd_seen  <= 1'b0;
			hi_nib    <= 1'b0;
			err       <= 1'b0;
			ovf       <= 1'b0;
			fifo_wr_o <= 1'b0;
		end else begin
			dv_q      <= phy_dv_i;
			fifo_wr_o <= eof_hold | byte_done | frame_end;
			if (lost && !fifo_wdata_o.eof)
				ovf <= 1'b1;                 // A data byte was dropped.
			if (phy_dv_i && !dv_q) begin     // Start of a new frame.
				err <= phy_rx_er_i;
				ovf <= 1'b0;
			end else if (phy_dv_i && phy_rx_er_i) begin
				err <= 1'b1;
			end

			if (!phy_dv_i) begin
				nib_5 <= 1'b0;
				if (frame_end)
					sfd_seen <= 1'b0;
			end else if (!sfd_seen) begin
				nib_5 <= (phy_rx_data_i == SFD_NIB_LO);
				if (nib_5 && phy_rx_data_i == SFD_NIB_HI) begin
					sfd_seen <= 1'b1;
					hi_nib   <= 1'b0;        // First data nibble is a low one.
				end
			end else begin
				hi_nib <= ~hi_nib;
			end
		end
	end

	// Byte assembly, low nibble first.
	always_ff @(posedge phy_rx_clk_i) begin
		if (phy_dv_i && sfd_seen && !hi_nib)
			low_nib <= phy_rx_data_i;
		if (byte_done)
			fifo_wdata_o <= '{data: {phy_rx_data_i, low_nib}, eof: 1'b0, bad: 1'b0};
		else if (frame_end)
			fifo_wdata_o <= '{data: 8'h00, eof: 1'b1, bad: err | ovf | lost};
	end

endmodule

// ==== mac_rx_pkg.sv ====
package mac_rx_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sizes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int WORD_ADR_W = 30;  // Word address of a 32-bit word.
	localparam int LEN_W      = 11;  // Byte count and MTU, room for 1500.

	// Start-of-frame delimiter 0xD5 as it arrives on MII, low nibble first.
	// Preamble nibbles are 5 as well, so the pair 5 then D marks the start.
	localparam logic [3:0] SFD_NIB_LO = 4'h5;
	localparam logic [3:0] SFD_NIB_HI = 4'hd;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Byte stream through the clock crossing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// One entry per received byte, plus one status entry at frame end.
	typedef struct packed {
		logic [7:0] data;  // Received byte, zero on a status entry.
		logic       eof;   // Status entry in place of a byte.
		logic       bad;   // On eof only. rx_er seen or bytes lost.
	} rx_byte_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus write
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic [WORD_ADR_W-1:0] adr;  // Word address.
		logic [31:0]           dat;  // Big-endian, first byte in [31:24].
	} bus_wr_t;

endpackage
